/* list.f */
src/trap_pkg.sv
src/trap_stage_if.sv
src/trap_capture.sv
src/trap_csr_file.sv
src/trap_redirect.sv
src/trap_unit_top.sv
verif/trap_unit_sva.sv
verif/trap_unit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the trap unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module trap_unit_tb -f list.f -o trap_unit_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/trap_unit_sim > sim.log 2>&1 || true
grep -q "^TESTS PASSED$" sim.log && echo "simulation passed" || {
  echo "simulation failed, see sim.log"
  exit 1
}

/* src/trap_capture.sv */
// trap capture stage, commit handshake receiver with exception priority and trap value select
`timescale 1ns/1ns
`default_nettype none

module trap_capture #(
  parameter int xlen = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        trap_req,
  output logic                        trap_ack,
  input  logic [trap_pkg::excp_w-1:0] excp_vec,
  input  logic                        is_mret,
  input  logic [xlen-1:0]             epc,
  input  logic [31:0]                 inst,
  input  logic [xlen-1:0]             mem_addr,
  trap_stage_if.src                   out
);

  logic            can_load;
  logic            load;
  logic            found;
  logic [5:0]      code;
  logic [xlen-1:0] tval;

  // register empty or draining this cycle
  assign can_load = !out.valid || !out.stall;
  assign load     = trap_req && !trap_ack && can_load;

  // four-phase receiver
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_ack <= 1'b0;
    end else if (trap_ack && !trap_req) begin
      trap_ack <= 1'b0;
    end else if (load) begin
      trap_ack <= 1'b1;
    end
  end

  // first set bit in priority order wins
  always_comb begin
    found = 1'b0;
    code  = '0;
    for (int i = 0; i < trap_pkg::excp_prio_n; i++) begin
      if (!found && excp_vec[trap_pkg::excp_prio[i][3:0]]) begin
        found = 1'b1;
        code  = trap_pkg::excp_prio[i];
      end
    end
  end

  always_comb begin
    tval = '0;
    if (found) begin
      case (code)
        trap_pkg::cause_inst_misal,
        trap_pkg::cause_inst_acc,
        trap_pkg::cause_inst_page:  tval = epc;
        trap_pkg::cause_ilg_inst:   tval = xlen'(inst);
        trap_pkg::cause_load_misal,
        trap_pkg::cause_load_acc,
        trap_pkg::cause_load_page,
        trap_pkg::cause_stor_misal,
        trap_pkg::cause_stor_acc,
        trap_pkg::cause_stor_page:  tval = mem_addr;
        default:                    tval = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out.valid <= 1'b0;
    end else if (load) begin
      out.valid <= 1'b1;
    end else if (!out.stall) begin
      out.valid <= 1'b0;
    end
  end

  // a faulting instruction never executes its mret
  always_ff @(posedge clk) begin
    if (load) begin
      out.is_mret   <= is_mret && !found;
      out.is_excp   <= found;
      out.excp_code <= code;
      out.epc       <= epc;
      out.tval      <= tval;
    end
  end

  // vector and interrupt flag are formed in the CSR stage
  assign out.tvec    = '0;
  assign out.is_intr = 1'b0;

endmodule

`default_nettype wire

/* src/trap_csr_file.sv */
// trap CSR stage, interrupt gating, trap CSR update and software CSR port
`timescale 1ns/1ns
`default_nettype none

module trap_csr_file #(
  parameter int xlen = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            irq_soft,
  input  logic            irq_timer,
  input  logic            irq_ext,
  input  logic            csr_wr_en,
  input  logic [11:0]     csr_addr,
  input  logic [xlen-1:0] csr_wr_data,
  output logic [xlen-1:0] csr_rd_data,
  trap_stage_if.dst       in,
  trap_stage_if.src       out
);

  // interrupt vectors ordered {ext, timer, soft}
  logic [2:0]      mip_r;
  logic [2:0]      mie_r;
  logic [2:0]      pend;
  logic            mst_mie;
  logic            mst_mpie;
  logic [xlen-1:2] mtvec_base;
  logic            mtvec_vec;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [xlen-1:0] mtvec_rd;
  logic            accept;
  logic            intr_take;
  logic            excp_take;
  logic            trap_take;
  logic [5:0]      intr_code;
  logic [5:0]      trap_code;
  logic [xlen-1:0] trap_tval;

  assign in.stall = out.valid && out.stall;
  assign accept   = in.valid && !in.stall;
  assign mtvec_rd = {mtvec_base, 1'b0, mtvec_vec};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mip_r <= '0;
    end else begin
      mip_r <= {irq_ext, irq_timer, irq_soft};
    end
  end

  // external, then software, then timer
  assign pend = mie_r & mip_r;
  always_comb begin
    if (pend[2]) begin
      intr_code = trap_pkg::cause_exter_itrp;
    end else if (pend[0]) begin
      intr_code = trap_pkg::cause_soft_itrp;
    end else begin
      intr_code = trap_pkg::cause_timer_itrp;
    end
  end

  assign intr_take = !in.is_mret && mst_mie && (|pend);
  assign excp_take = !in.is_mret && !intr_take && in.is_excp;
  assign trap_take = intr_take || excp_take;
  assign trap_code = intr_take ? intr_code : in.excp_code;
  assign trap_tval = intr_take ? '0 : in.tval;

  // trap updates come last so a same-cycle software write loses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mst_mie    <= 1'b0;
      mst_mpie   <= 1'b0;
      mie_r      <= '0;
      mtvec_base <= '0;
      mtvec_vec  <= 1'b0;
      mscratch   <= '0;
      mepc       <= '0;
      mcause     <= '0;
      mtval      <= '0;
    end else begin
      if (csr_wr_en) begin
        case (csr_addr)
          trap_pkg::csr_mstatus: begin
            mst_mie  <= csr_wr_data[trap_pkg::mstatus_mie_bit];
            mst_mpie <= csr_wr_data[trap_pkg::mstatus_mpie_bit];
          end
          trap_pkg::csr_mie: begin
            mie_r <= {csr_wr_data[trap_pkg::cause_exter_itrp],
                      csr_wr_data[trap_pkg::cause_timer_itrp],
                      csr_wr_data[trap_pkg::cause_soft_itrp]};
          end
          trap_pkg::csr_mtvec: begin
            mtvec_base <= csr_wr_data[xlen-1:2];
            // modes 2 and 3 fall back to direct
            mtvec_vec  <= (csr_wr_data[1:0] == 2'b01);
          end
          trap_pkg::csr_mscratch: mscratch <= csr_wr_data;
          trap_pkg::csr_mepc:     mepc     <= csr_wr_data;
          trap_pkg::csr_mcause:   mcause   <= csr_wr_data;
          trap_pkg::csr_mtval:    mtval    <= csr_wr_data;
          default: begin
          end
        endcase
      end
      if (accept && in.is_mret) begin
        mst_mie  <= mst_mpie;
        mst_mpie <= 1'b1;
      end else if (accept && trap_take) begin
        mepc             <= in.epc;
        mcause           <= '0;
        mcause[xlen-1]   <= intr_take;
        mcause[5:0]      <= trap_code;
        mtval            <= trap_tval;
        mst_mpie         <= mst_mie;
        mst_mie          <= 1'b0;
      end
    end
  end

  // dropped interrupt checks never reach redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out.valid <= 1'b0;
    end else if (accept) begin
      out.valid <= in.is_mret || trap_take;
    end else if (!out.stall) begin
      out.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out.is_mret   <= in.is_mret;
      out.is_excp   <= excp_take;
      out.is_intr   <= intr_take;
      out.excp_code <= trap_code;
      out.epc       <= in.epc;
      out.tval      <= trap_tval;
      out.tvec      <= in.is_mret ? mepc : mtvec_rd;
    end
  end

  always_comb begin
    csr_rd_data = '0;
    case (csr_addr)
      trap_pkg::csr_mstatus: begin
        csr_rd_data[trap_pkg::mstatus_mie_bit]  = mst_mie;
        csr_rd_data[trap_pkg::mstatus_mpie_bit] = mst_mpie;
      end
      trap_pkg::csr_mie: begin
        csr_rd_data[trap_pkg::cause_exter_itrp] = mie_r[2];
        csr_rd_data[trap_pkg::cause_timer_itrp] = mie_r[1];
        csr_rd_data[trap_pkg::cause_soft_itrp]  = mie_r[0];
      end
      trap_pkg::csr_mip: begin
        csr_rd_data[trap_pkg::cause_exter_itrp] = mip_r[2];
        csr_rd_data[trap_pkg::cause_timer_itrp] = mip_r[1];
        csr_rd_data[trap_pkg::cause_soft_itrp]  = mip_r[0];
      end
      trap_pkg::csr_mtvec:    csr_rd_data = mtvec_rd;
      trap_pkg::csr_mscratch: csr_rd_data = mscratch;
      trap_pkg::csr_mepc:     csr_rd_data = mepc;
      trap_pkg::csr_mcause:   csr_rd_data = mcause;
      trap_pkg::csr_mtval:    csr_rd_data = mtval;
      default:                csr_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/trap_pkg.sv */
// trap unit package, cause codes, CSR addresses, mstatus fields and exception priority
`default_nettype none

package trap_pkg;

  // one bit per exception cause code
  parameter int excp_w = 16;

  // exception cause codes
  parameter logic [5:0] cause_inst_misal = 6'd0;
  parameter logic [5:0] cause_inst_acc   = 6'd1;
  parameter logic [5:0] cause_ilg_inst   = 6'd2;
  parameter logic [5:0] cause_brk_pt     = 6'd3;
  parameter logic [5:0] cause_load_misal = 6'd4;
  parameter logic [5:0] cause_load_acc   = 6'd5;
  parameter logic [5:0] cause_stor_misal = 6'd6;
  parameter logic [5:0] cause_stor_acc   = 6'd7;
  parameter logic [5:0] cause_ecall_m    = 6'd11;
  parameter logic [5:0] cause_inst_page  = 6'd12;
  parameter logic [5:0] cause_load_page  = 6'd13;
  parameter logic [5:0] cause_stor_page  = 6'd15;

  // interrupt cause codes, also the mie and mip bit positions
  parameter logic [5:0] cause_soft_itrp  = 6'd3;
  parameter logic [5:0] cause_timer_itrp = 6'd7;
  parameter logic [5:0] cause_exter_itrp = 6'd11;

  // exception priority, highest first; load beats store on a tie
  parameter int excp_prio_n = 12;
  parameter logic [5:0] excp_prio [excp_prio_n] = '{
    cause_brk_pt,
    cause_inst_page,
    cause_inst_acc,
    cause_inst_misal,
    cause_ilg_inst,
    cause_ecall_m,
    cause_load_misal,
    cause_stor_misal,
    cause_load_page,
    cause_stor_page,
    cause_load_acc,
    cause_stor_acc
  };

  // machine trap CSR addresses
  parameter logic [11:0] csr_mstatus  = 12'h300;
  parameter logic [11:0] csr_mie      = 12'h304;
  parameter logic [11:0] csr_mtvec    = 12'h305;
  parameter logic [11:0] csr_mscratch = 12'h340;
  parameter logic [11:0] csr_mepc     = 12'h341;
  parameter logic [11:0] csr_mcause   = 12'h342;
  parameter logic [11:0] csr_mtval    = 12'h343;
  parameter logic [11:0] csr_mip      = 12'h344;

  // mstatus fields kept by this unit
  parameter int mstatus_mie_bit  = 3;
  parameter int mstatus_mpie_bit = 7;

endpackage

`default_nettype wire

/* src/trap_redirect.sv */
// trap redirect stage, target select and four-phase sender toward fetch
`timescale 1ns/1ns
`default_nettype none

module trap_redirect #(
  parameter int xlen = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  trap_stage_if.dst       in,
  output logic            redir_req,
  input  logic            redir_ack,
  output logic [xlen-1:0] redir_pc,
  output logic [xlen-1:0] redir_cause
);

  // sender states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_arm  = 2'd1;
  localparam logic [1:0] st_req  = 2'd2;
  localparam logic [1:0] st_drop = 2'd3;

  logic [1:0]      state;
  logic            leaving;
  logic            load;
  logic [xlen-1:0] base;
  logic [xlen-1:0] target;
  logic [xlen-1:0] cause;

  // slot frees up once ack has dropped
  assign leaving  = (state == st_drop) && !redir_ack;
  assign in.stall = (state != st_idle) && !leaving;
  assign load     = in.valid && !in.stall;

  assign base = {in.tvec[xlen-1:2], 2'b00};

  always_comb begin
    if (in.is_mret) begin
      target = in.tvec;
    end else if (in.tvec[0] && in.is_intr) begin
      // vectored interrupt, one word per cause
      target = base + (xlen'(in.excp_code) << 2);
    end else begin
      target = base;
    end
  end

  always_comb begin
    cause = '0;
    if (!in.is_mret) begin
      cause[xlen-1] = in.is_intr;
      cause[5:0]    = in.excp_code;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (load) state <= st_arm;
        st_arm:  state <= st_req;
        st_req:  if (redir_ack) state <= st_drop;
        st_drop: begin
          if (!redir_ack) begin
            state <= load ? st_arm : st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // held stable for the whole request
  always_ff @(posedge clk) begin
    if (load) begin
      redir_pc    <= target;
      redir_cause <= cause;
    end
  end

  assign redir_req = (state == st_req);

endmodule

`default_nettype wire

/* src/trap_stage_if.sv */
// trap stage link, one trap event passed between two pipeline stages
`timescale 1ns/1ns
`default_nettype none

interface trap_stage_if #(
  parameter int xlen = 64
);

  logic            valid;
  logic            stall;
  logic            is_mret;
  logic            is_excp;
  logic [5:0]      excp_code;
  logic [xlen-1:0] epc;
  logic [xlen-1:0] tval;
  // only meaningful from the CSR stage onward
  logic [xlen-1:0] tvec;
  logic            is_intr;

  modport src (
    output valid, is_mret, is_excp, excp_code, epc, tval, tvec, is_intr,
    input  stall
  );

  modport dst (
    input  valid, is_mret, is_excp, excp_code, epc, tval, tvec, is_intr,
    output stall
  );

endinterface

`default_nettype wire

/* src/trap_unit_top.sv */
// machine-mode trap unit, three-stage capture, CSR and redirect pipeline
`timescale 1ns/1ns
`default_nettype none

module trap_unit_top #(
  parameter int xlen = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // commit side
  input  logic                        trap_req,
  output logic                        trap_ack,
  input  logic [trap_pkg::excp_w-1:0] excp_vec,
  input  logic                        is_mret,
  input  logic [xlen-1:0]             epc,
  input  logic [31:0]                 inst,
  input  logic [xlen-1:0]             mem_addr,
  // interrupt lines
  input  logic                        irq_soft,
  input  logic                        irq_timer,
  input  logic                        irq_ext,
  // software CSR port
  input  logic                        csr_wr_en,
  input  logic [11:0]                 csr_addr,
  input  logic [xlen-1:0]             csr_wr_data,
  output logic [xlen-1:0]             csr_rd_data,
  // fetch side
  output logic                        redir_req,
  input  logic                        redir_ack,
  output logic [xlen-1:0]             redir_pc,
  output logic [xlen-1:0]             redir_cause
);

  trap_stage_if #(.xlen(xlen)) s1_to_s2 ();
  trap_stage_if #(.xlen(xlen)) s2_to_s3 ();

  trap_capture #(.xlen(xlen)) u_trap_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .trap_req (trap_req),
    .trap_ack (trap_ack),
    .excp_vec (excp_vec),
    .is_mret  (is_mret),
    .epc      (epc),
    .inst     (inst),
    .mem_addr (mem_addr),
    .out      (s1_to_s2.src)
  );

  trap_csr_file #(.xlen(xlen)) u_trap_csr_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_soft    (irq_soft),
    .irq_timer   (irq_timer),
    .irq_ext     (irq_ext),
    .csr_wr_en   (csr_wr_en),
    .csr_addr    (csr_addr),
    .csr_wr_data (csr_wr_data),
    .csr_rd_data (csr_rd_data),
    .in          (s1_to_s2.dst),
    .out         (s2_to_s3.src)
  );

  trap_redirect #(.xlen(xlen)) u_trap_redirect (
    .clk         (clk),
    .rst_n       (rst_n),
    .in          (s2_to_s3.dst),
    .redir_req   (redir_req),
    .redir_ack   (redir_ack),
    .redir_pc    (redir_pc),
    .redir_cause (redir_cause)
  );

endmodule

`default_nettype wire

/* verif/trap_unit_sva.sv */
// trap unit assertions, commit and fetch handshakes and reset values
`timescale 1ns/1ns
`default_nettype none

module trap_unit_sva #(
  parameter int xlen = 64
) (
  input wire logic                        clk,
  input wire logic                        rst_n,
  input wire logic                        trap_req,
  input wire logic                        trap_ack,
  input wire logic [trap_pkg::excp_w-1:0] excp_vec,
  input wire logic [xlen-1:0]             epc,
  input wire logic                        redir_req,
  input wire logic [xlen-1:0]             redir_pc
);

  // payload held until the receiver answers
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    trap_req && !trap_ack |=> trap_req && $stable(excp_vec) && $stable(epc))
    else $error("trap_req or payload changed before trap_ack");

  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    trap_ack && trap_req |=> trap_ack)
    else $error("trap_ack fell while trap_req still high");

  a_redir_stable: assert property (@(posedge clk) disable iff (!rst_n)
    redir_req |=> !redir_req || $stable(redir_pc))
    else $error("redir_pc changed during a redirect request");

  a_reset_low: assert property (@(posedge clk)
    !rst_n |-> !trap_ack && !redir_req)
    else $error("handshake outputs high during reset");

endmodule

bind trap_unit_top trap_unit_sva #(.xlen(xlen)) u_trap_unit_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .trap_req  (trap_req),
  .trap_ack  (trap_ack),
  .excp_vec  (excp_vec),
  .epc       (epc),
  .redir_req (redir_req),
  .redir_pc  (redir_pc)
);

`default_nettype wire

/* verif/trap_unit_tb.sv */
// trap unit testbench driving table rows of traps, interrupts and mret plus fetch back-pressure
`timescale 1ns/1ns
`default_nettype none

module trap_unit_tb;

  localparam int n_rows = 11;
  localparam int bp_n   = 6;
  localparam int limit  = (n_rows + bp_n + 1) * 40 + 100;

  typedef struct {
    logic [63:0] mst;
    logic [63:0] mie;
    logic [63:0] mtvec;
    logic [2:0]  irq;
    logic [15:0] excp;
    logic        mret;
    logic [63:0] epc;
    logic [31:0] inst;
    logic [63:0] maddr;
    logic        redir;
    logic [63:0] pc;
    logic [63:0] cause;
    logic [63:0] mepc;
    logic [63:0] mtval;
    logic [63:0] mstat;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        trap_req;
  logic        trap_ack;
  logic [15:0] excp_vec;
  logic        is_mret;
  logic [63:0] epc;
  logic [31:0] inst;
  logic [63:0] mem_addr;
  logic        irq_soft;
  logic        irq_timer;
  logic        irq_ext;
  logic        csr_wr_en;
  logic [11:0] csr_addr;
  logic [63:0] csr_wr_data;
  logic [63:0] csr_rd_data;
  logic        redir_req;
  logic        redir_ack;
  logic [63:0] redir_pc;
  logic [63:0] redir_cause;

  row_t        rows [n_rows];
  logic [5:0]  bp_codes [bp_n] = '{6'd2, 6'd5, 6'd1, 6'd7, 6'd0, 6'd3};
  logic [63:0] got_pc [$];
  logic [63:0] got_cause [$];
  int          got_cyc [$];
  int          cycles;
  int          ack_cycle;
  int          errors;
  int          checks;
  logic [63:0] rd;
  logic [63:0] exp_mcause;

  trap_unit_top #(.xlen(64)) u_trap_unit_top (
    .clk(clk), .rst_n(rst_n), .trap_req(trap_req), .trap_ack(trap_ack),
    .excp_vec(excp_vec), .is_mret(is_mret), .epc(epc), .inst(inst),
    .mem_addr(mem_addr), .irq_soft(irq_soft), .irq_timer(irq_timer),
    .irq_ext(irq_ext), .csr_wr_en(csr_wr_en), .csr_addr(csr_addr),
    .csr_wr_data(csr_wr_data), .csr_rd_data(csr_rd_data),
    .redir_req(redir_req), .redir_ack(redir_ack), .redir_pc(redir_pc),
    .redir_cause(redir_cause)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // fetch side answers each redirect after a random delay
  initial begin
    int unsigned d;
    redir_ack = 1'b0;
    void'($urandom(32'hf995));
    wait (rst_n === 1'b1);
    forever begin
      do @(negedge clk); while (!redir_req);
      got_pc.push_back(redir_pc);
      got_cause.push_back(redir_cause);
      got_cyc.push_back(cycles);
      d = $urandom % 4;
      repeat (d) @(posedge clk);
      @(posedge clk);
      redir_ack <= 1'b1;
      do @(negedge clk); while (redir_req);
      @(posedge clk);
      redir_ack <= 1'b0;
    end
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [63:0] v);
    @(posedge clk);
    csr_wr_en   <= 1'b1;
    csr_addr    <= a;
    csr_wr_data <= v;
    @(posedge clk);
    csr_wr_en   <= 1'b0;
  endtask

  task automatic csr_read(input logic [11:0] a, output logic [63:0] v);
    @(posedge clk);
    csr_addr <= a;
    @(negedge clk);
    v = csr_rd_data;
  endtask

  // four-phase commit request
  task automatic commit(input logic [15:0] ev, input logic mr, input logic [63:0] pc_in,
                        input logic [31:0] ins, input logic [63:0] ma);
    @(posedge clk);
    trap_req <= 1'b1;
    excp_vec <= ev;
    is_mret  <= mr;
    epc      <= pc_in;
    inst     <= ins;
    mem_addr <= ma;
    do @(negedge clk); while (!trap_ack);
    ack_cycle = cycles;
    @(posedge clk);
    trap_req <= 1'b0;
    do @(negedge clk); while (trap_ack);
  endtask

  task automatic run_row(input int i);
    int e0;
    e0 = errors;
    // mcause only moves on a taken trap
    if (rows[i].redir && !rows[i].mret) begin
      exp_mcause = rows[i].cause;
    end
    csr_write(12'h300, rows[i].mst);
    csr_write(12'h304, rows[i].mie);
    csr_write(12'h305, rows[i].mtvec);
    @(posedge clk);
    {irq_ext, irq_timer, irq_soft} <= rows[i].irq;
    repeat (2) @(posedge clk);
    commit(rows[i].excp, rows[i].mret, rows[i].epc, rows[i].inst, rows[i].maddr);
    if (rows[i].redir) begin
      while (got_pc.size() == 0) @(negedge clk);
      check_val("redir_pc", got_pc.pop_front(), rows[i].pc);
      check_val("redir_cause", got_cause.pop_front(), rows[i].cause);
      check_val("redir_req latency", 64'(got_cyc.pop_front() - ack_cycle), 64'd3);
    end else begin
      repeat (5) @(negedge clk);
      if (got_pc.size() != 0) begin
        $display("error at %0t: unexpected redirect for row %0d", $time, i);
        errors++;
        got_pc.delete();
        got_cause.delete();
        got_cyc.delete();
      end
    end
    csr_read(12'h341, rd);
    check_val("mepc", rd, rows[i].mepc);
    csr_read(12'h343, rd);
    check_val("mtval", rd, rows[i].mtval);
    csr_read(12'h300, rd);
    check_val("mstatus", rd, rows[i].mstat);
    csr_read(12'h342, rd);
    check_val("mcause", rd, exp_mcause);
    // mip bits sit at the interrupt cause positions
    csr_read(12'h344, rd);
    check_val("mip", rd, {52'h0, rows[i].irq[2], 3'b000, rows[i].irq[1], 3'b000,
                          rows[i].irq[0], 3'b000});
    $display("row %0d done, %0d errors", i, errors - e0);
  endtask

  initial begin
    // exception, priority, interrupt, masked and mret rows
    rows[0] = '{64'h8, 64'h0, 64'h1000, 3'b000, 16'h0004, 1'b0, 64'h200, 32'hdeadbeef,
                64'h0, 1'b1, 64'h1000, 64'd2, 64'h200, 64'hdeadbeef, 64'h80};
    rows[1] = '{64'h0, 64'h0, 64'h2001, 3'b000, 16'h0020, 1'b0, 64'h300, 32'h0,
                64'h4444, 1'b1, 64'h2000, 64'd5, 64'h300, 64'h4444, 64'h0};
    rows[2] = '{64'h8, 64'h0, 64'h3000, 3'b000, 16'h8806, 1'b0, 64'h400, 32'h0,
                64'h9999, 1'b1, 64'h3000, 64'd1, 64'h400, 64'h400, 64'h80};
    rows[3] = '{64'h0, 64'h0, 64'h3000, 3'b000, 16'h0050, 1'b0, 64'h500, 32'h0,
                64'h5555, 1'b1, 64'h3000, 64'd4, 64'h500, 64'h5555, 64'h0};
    rows[4] = '{64'h8, 64'h80, 64'h4001, 3'b010, 16'h0004, 1'b0, 64'h600, 32'h13,
                64'h0, 1'b1, 64'h401c, 64'h8000_0000_0000_0007, 64'h600, 64'h0, 64'h80};
    rows[5] = '{64'h0, 64'h888, 64'h4001, 3'b100, 16'h0000, 1'b0, 64'h650, 32'h0,
                64'h0, 1'b0, 64'h0, 64'h0, 64'h600, 64'h0, 64'h0};
    rows[6] = '{64'h80, 64'h0, 64'h4001, 3'b000, 16'h0000, 1'b1, 64'h0, 32'h0,
                64'h0, 1'b1, 64'h600, 64'h0, 64'h600, 64'h0, 64'h88};
    rows[7] = '{64'h8, 64'h808, 64'h5001, 3'b101, 16'h0000, 1'b0, 64'h700, 32'h0,
                64'h0, 1'b1, 64'h502c, 64'h8000_0000_0000_000b, 64'h700, 64'h0, 64'h80};
    rows[8] = '{64'h0, 64'h0, 64'h6003, 3'b000, 16'h1008, 1'b0, 64'h800, 32'h0,
                64'h0, 1'b1, 64'h6000, 64'd3, 64'h800, 64'h0, 64'h0};
    rows[9] = '{64'h8, 64'h8, 64'h4001, 3'b110, 16'h0000, 1'b0, 64'h880, 32'h0,
                64'h0, 1'b0, 64'h0, 64'h0, 64'h800, 64'h0, 64'h8};
    rows[10] = '{64'h8, 64'h88, 64'h4001, 3'b011, 16'h0000, 1'b0, 64'h680, 32'h0,
                 64'h0, 1'b1, 64'h400c, 64'h8000_0000_0000_0003, 64'h680, 64'h0, 64'h80};
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    errors = 0;
    checks = 0;
    exp_mcause = '0;
    {trap_req, is_mret, excp_vec, epc, inst, mem_addr} = '0;
    {irq_soft, irq_timer, irq_ext} = '0;
    {csr_wr_en, csr_addr, csr_wr_data} = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // software CSR port
    csr_write(12'h305, 64'h7003);
    csr_read(12'h305, rd);
    check_val("mtvec", rd, 64'h7000);
    csr_write(12'h305, 64'h7001);
    csr_read(12'h305, rd);
    check_val("mtvec", rd, 64'h7001);
    csr_write(12'h304, '1);
    csr_read(12'h304, rd);
    check_val("mie", rd, 64'h888);
    csr_write(12'h340, 64'h0123_4567_89ab_cdef);
    csr_read(12'h340, rd);
    check_val("mscratch", rd, 64'h0123_4567_89ab_cdef);
    csr_write(12'h300, '1);
    csr_read(12'h300, rd);
    check_val("mstatus", rd, 64'h88);
    $display("csr port test done, %0d errors", errors);

    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end

    // back-to-back exceptions against a slow fetch side
    csr_write(12'h300, 64'h0);
    csr_write(12'h304, 64'h0);
    csr_write(12'h305, 64'h1000);
    @(posedge clk);
    {irq_ext, irq_timer, irq_soft} <= 3'b000;
    for (int i = 0; i < bp_n; i++) begin
      commit(16'(1) << bp_codes[i], 1'b0, 64'h900 + 64'(i * 4), 32'h0, 64'h0);
    end
    while (got_pc.size() < bp_n) @(negedge clk);
    repeat (5) @(negedge clk);
    if (got_pc.size() != bp_n) begin
      $display("error at %0t: %0d redirects seen, %0d expected", $time, got_pc.size(), bp_n);
      errors++;
    end
    for (int i = 0; i < bp_n; i++) begin
      check_val("redir_pc", got_pc.pop_front(), 64'h1000);
      check_val("redir_cause", got_cause.pop_front(), 64'(bp_codes[i]));
    end
    $display("back-pressure test done, %0d errors", errors);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
